// File: engine.f
design/engine_pkg.sv
design/atom_if.sv
design/dma_deserializer.sv
design/mac_pool_array.sv
design/writeback_serializer.sv
design/engine.sv
tb/engine_sva.sv
tb/engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the engine testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module engine_tb \
	-f engine.f -Mdir obj_dir -o engine_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/engine_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
	echo "Simulation ended without a verdict"
	exit 1
fi

exit 0

// File: tb/engine_tb.sv
`timescale 1ns/1ns

module engine_tb;

	logic                          clk = 1'b0;
	logic                          rst = 1'b0;
	logic                          i_engine_valid = 1'b0;
	logic [2:0]                    i_op_type = '0;
	logic [7:0]                    i_kernel_size = '0;
	logic [engine_pkg::CNT_W-1:0]  i_out_count = '0;
	logic [3:0]                    i_ave_shift = '0;
	logic [engine_pkg::ADDR_W-1:0] i_data_start_addr = '0;
	logic [engine_pkg::ADDR_W-1:0] i_weight_start_addr = '0;
	logic [engine_pkg::ADDR_W-1:0] i_result_start_addr = '0;
	engine_pkg::word_t             i_dma_p2_ob_data = '0;
	engine_pkg::word_t             i_dma_p3_ob_data = '0;
	logic                          i_dma_p2_ob_we = 1'b0;
	logic                          i_dma_p3_ob_we = 1'b0;
	logic                          i_dma_p0_ib_re = 1'b0;
	logic                          o_engine_ready, o_dma_p0_ib_valid;
	logic                          o_dma_p2_reads_en, o_dma_p3_reads_en, o_dma_p0_writes_en;
	logic [engine_pkg::ADDR_W-1:0] o_p2_addr, o_p3_addr, o_p0_addr;
	engine_pkg::word_t             o_dma_p0_ib_data;

	integer            seed = 42723;
	engine_pkg::word_t mem [1024];       // Activations and weights
	bit                written [1024];   // Result addresses seen on port 0
	logic [2:0]        cfg_op = '0;
	int                cfg_ks = 1, cfg_shift = 0, cfg_pct = 50;
	int                cfg_dstart = 0, cfg_wstart = 0, cfg_rstart = 0;
	int                dcount = 0, wcount = 0, wr_count = 0, widx = 0;
	logic              p2_acc = 1'b0, p3_acc = 1'b0;   // Words taken in the last cycle
	int                mon_errs = 0, seq_errs = 0, pass_cnt = 0, fail_cnt = 0;
	logic              hung = 1'b0;

	engine dut (
		.clk (clk), .rst (rst), .i_engine_valid (i_engine_valid),
		.i_op_type (i_op_type), .i_kernel_size (i_kernel_size),
		.i_out_count (i_out_count), .i_ave_shift (i_ave_shift),
		.i_data_start_addr (i_data_start_addr), .i_weight_start_addr (i_weight_start_addr),
		.i_result_start_addr (i_result_start_addr),
		.i_dma_p2_ob_data (i_dma_p2_ob_data), .i_dma_p3_ob_data (i_dma_p3_ob_data),
		.i_dma_p2_ob_we (i_dma_p2_ob_we), .i_dma_p3_ob_we (i_dma_p3_ob_we),
		.i_dma_p0_ib_re (i_dma_p0_ib_re), .o_engine_ready (o_engine_ready),
		.o_dma_p2_reads_en (o_dma_p2_reads_en), .o_dma_p3_reads_en (o_dma_p3_reads_en),
		.o_dma_p0_writes_en (o_dma_p0_writes_en), .o_p2_addr (o_p2_addr),
		.o_p3_addr (o_p3_addr), .o_p0_addr (o_p0_addr),
		.o_dma_p0_ib_data (o_dma_p0_ib_data), .o_dma_p0_ib_valid (o_dma_p0_ib_valid)
	);

	always #50 clk = ~clk;   // 100 ns period

	function automatic int mem_idx(input int a);
		return a % 1024;
	endfunction

	function automatic logic strobe(input int pct);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return (r % 100) < pct;
	endfunction

	// Expected word for output o, lane k, straight from the op rules
	function automatic engine_pkg::word_t model_word(input int o, input int k);
		int                acc;
		int                t;
		engine_pkg::word_t d, w, m;
		acc = 0;
		m   = '0;
		for (t = 0; t < cfg_ks; t++) begin
			d = mem[mem_idx(cfg_dstart + (o * cfg_ks + t) * engine_pkg::LANES + k)];
			w = mem[mem_idx(cfg_wstart + t * engine_pkg::LANES + k)];
			if (cfg_op == engine_pkg::OP_MPOOL) begin
				if (t == 0 || d > m)
					m = d;
			end else if (cfg_op == engine_pkg::OP_APOOL) begin
				m = m + d;   // Sum wraps at word width
			end else begin
				acc = acc + int'(d) * int'(w);
			end
		end
		if (cfg_op == engine_pkg::OP_MPOOL)
			return m;
		if (cfg_op == engine_pkg::OP_APOOL)
			return m >>> cfg_shift;
		return engine_pkg::word_t'(acc);   // Low half of the product sum
	endfunction

	task automatic check_word(input engine_pkg::word_t got, input engine_pkg::word_t exp,
			input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			mon_errs++;
		end
	endtask

	task automatic check_addr(input logic [engine_pkg::ADDR_W-1:0] got,
			input logic [engine_pkg::ADDR_W-1:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			mon_errs++;
		end
	endtask

	// DMA read side, data follows the model's own word counters
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 1024; i++)
				mem[i] = engine_pkg::word_t'($random(seed));
		end
		if (!i_engine_valid) begin
			dcount = 0;
			wcount = 0;
		end else begin
			if (p2_acc)
				dcount = dcount + 1;
			if (p3_acc)
				wcount = wcount + 1;   // Weights wrap every output
		end
		i_dma_p2_ob_we   <= strobe(cfg_pct);
		i_dma_p3_ob_we   <= strobe(cfg_pct);
		i_dma_p0_ib_re   <= strobe(cfg_pct);
		i_dma_p2_ob_data <= mem[mem_idx(cfg_dstart + dcount)];
		i_dma_p3_ob_data <= mem[mem_idx(cfg_wstart + wcount % (cfg_ks * engine_pkg::LANES))];
	end

	// Monitor on the falling edge where outputs are settled
	always @(negedge clk) begin
		p2_acc = o_dma_p2_reads_en & i_dma_p2_ob_we;
		p3_acc = o_dma_p3_reads_en & i_dma_p3_ob_we;
		if (o_dma_p2_reads_en)
			check_addr(o_p2_addr, engine_pkg::ADDR_W'(cfg_dstart + dcount), "data address");
		if (o_dma_p3_reads_en)   // Tap t, lane k sits at t*LANES+k past the base
			check_addr(o_p3_addr, engine_pkg::ADDR_W'(cfg_wstart +
				wcount % (cfg_ks * engine_pkg::LANES)), "weight address");
		if (!i_engine_valid)
			wr_count = 0;
		if (i_engine_valid && o_dma_p3_reads_en &&
				(cfg_op == engine_pkg::OP_MPOOL || cfg_op == engine_pkg::OP_APOOL)) begin
			$display("Weight read enabled during a pool layer at time %0t", $time);
			mon_errs++;
		end
		if (o_dma_p0_ib_valid) begin
			check_addr(o_p0_addr, engine_pkg::ADDR_W'(cfg_rstart + wr_count), "result address");
			check_word(o_dma_p0_ib_data, model_word(wr_count / engine_pkg::LANES,
				wr_count % engine_pkg::LANES), "result word");
			widx = int'(o_p0_addr[9:0]);
			if (written[widx]) begin
				$display("Result address %h was written twice", o_p0_addr);
				mon_errs++;
			end
			written[widx] = 1'b1;
			wr_count++;
		end
	end

	task automatic wait_ready(input logic level, input string name);
		int n;
		n = 0;
		while (o_engine_ready !== level && n < 5000) begin
			@(negedge clk);
			n++;
		end
		if (o_engine_ready !== level) begin
			$display("%s timed out waiting for engine_ready to become %0d", name, level);
			hung = 1'b1;
		end
	endtask

	// One layer from launch to idle, entered and left on a falling edge
	task automatic run_layer(input string name, input logic [2:0] op, input int ks,
			input int outs, input int shift, input int dstart, input int wstart,
			input int rstart, input int pct);
		int errs_before;
		int n;
		int seen;
		errs_before = mon_errs + seq_errs;
		if (hung)
			return;
		cfg_op     = op;
		cfg_ks     = ks;
		cfg_shift  = shift;
		cfg_dstart = dstart;
		cfg_wstart = wstart;
		cfg_rstart = rstart;
		cfg_pct    = pct;
		@(posedge clk);
		i_op_type           <= op;
		i_kernel_size       <= 8'(ks);
		i_out_count         <= engine_pkg::CNT_W'(outs);
		i_ave_shift         <= 4'(shift);
		i_data_start_addr   <= engine_pkg::ADDR_W'(dstart);
		i_weight_start_addr <= engine_pkg::ADDR_W'(wstart);
		i_result_start_addr <= engine_pkg::ADDR_W'(rstart);
		i_engine_valid      <= 1'b1;
		@(negedge clk);
		wait_ready(1'b1, name);
		if (hung)
			return;
		if (wr_count != outs * engine_pkg::LANES) begin
			$display("%s: engine_ready rose after %0d of %0d words", name, wr_count,
				outs * engine_pkg::LANES);
			seq_errs++;
		end
		repeat (3) begin
			@(negedge clk);
			if (!o_engine_ready) begin
				$display("%s: engine_ready dropped while engine_valid was high", name);
				seq_errs++;
			end
		end
		@(posedge clk);
		i_engine_valid <= 1'b0;
		@(negedge clk);
		wait_ready(1'b0, name);
		if (hung)
			return;
		seen = 0;
		for (n = 0; n < outs * engine_pkg::LANES; n++)
			if (written[mem_idx(rstart + n)])
				seen++;
		if (seen != outs * engine_pkg::LANES) begin
			$display("%s: only %0d distinct result addresses written", name, seen);
			seq_errs++;
		end
		if (mon_errs + seq_errs == errs_before)
			pass_cnt++;
		else
			fail_cnt++;
		$display("Test %s done, %0d words, %0d errors", name, seen,
			mon_errs + seq_errs - errs_before);
	endtask

	initial begin
		rst <= 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		run_layer("conv", engine_pkg::OP_CONV, 9, 3, 0, 'h000, 'h100, 'h200, 70);
		run_layer("max_pool", engine_pkg::OP_MPOOL, 4, 3, 0, 'h080, 'h100, 'h210, 70);
		run_layer("avg_pool", engine_pkg::OP_APOOL, 4, 3, 2, 'h0c0, 'h100, 'h220, 70);
		run_layer("back_pressure", 3'd2, 3, 5, 0, 'h140, 'h180, 'h240, 20);   // Unknown op runs as CONV
		run_layer("second_layer", engine_pkg::OP_CONV, 2, 2, 0, 'h1c0, 'h1e0, 'h260, 50);
		$display("Tests: %0d passed, %0d failed, %0d check errors", pass_cnt, fail_cnt,
			mon_errs + seq_errs);
		if (!hung && fail_cnt == 0 && mon_errs + seq_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb/engine_sva.sv
`timescale 1ns/1ns

module engine_sva (
	input logic clk,
	input logic rst,
	input logic i_ib_re,
	input logic i_writes_en,
	input logic i_ib_valid,
	input logic i_p2_reads_en,
	input logic i_p3_reads_en,
	input logic i_engine_ready
);

	// Write port answers exactly one cycle after an accepted ib_re
	a_valid_after_re: assert property (@(posedge clk) disable iff (rst)
		i_ib_valid |-> $past(i_ib_re && i_writes_en))
		else $error("ib_valid without an accepted ib_re one cycle before");

	a_re_gets_valid: assert property (@(posedge clk) disable iff (rst)
		(i_ib_re && i_writes_en) |=> i_ib_valid)
		else $error("accepted ib_re not followed by ib_valid");

	// Quiet in reset and the first cycle after it
	a_quiet_reset: assert property (@(posedge clk)
		(rst || $past(rst)) |-> !(i_p2_reads_en || i_p3_reads_en || i_engine_ready))
		else $error("reads_en or engine_ready high around reset");

	a_ready_alone: assert property (@(posedge clk) disable iff (rst)
		!(i_engine_ready && i_writes_en))   // Done only once writes are over
		else $error("engine_ready and writes_en high together");

endmodule

bind engine engine_sva u_sva (
	.clk            (clk),
	.rst            (rst),
	.i_ib_re        (i_dma_p0_ib_re),
	.i_writes_en    (o_dma_p0_writes_en),
	.i_ib_valid     (o_dma_p0_ib_valid),
	.i_p2_reads_en  (o_dma_p2_reads_en),
	.i_p3_reads_en  (o_dma_p3_reads_en),
	.i_engine_ready (o_engine_ready)
);

// File: design/engine.sv
`timescale 1ns/1ns

module engine (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_engine_valid,
	input  logic [2:0]                    i_op_type,
	input  logic [7:0]                    i_kernel_size,
	input  logic [engine_pkg::CNT_W-1:0]  i_out_count,
	input  logic [3:0]                    i_ave_shift,
	input  logic [engine_pkg::ADDR_W-1:0] i_data_start_addr,
	input  logic [engine_pkg::ADDR_W-1:0] i_weight_start_addr,
	input  logic [engine_pkg::ADDR_W-1:0] i_result_start_addr,
	input  engine_pkg::word_t             i_dma_p2_ob_data,
	input  engine_pkg::word_t             i_dma_p3_ob_data,
	input  logic                          i_dma_p2_ob_we,
	input  logic                          i_dma_p3_ob_we,
	input  logic                          i_dma_p0_ib_re,
	output logic                          o_engine_ready,
	output logic                          o_dma_p2_reads_en,
	output logic                          o_dma_p3_reads_en,
	output logic                          o_dma_p0_writes_en,
	output logic [engine_pkg::ADDR_W-1:0] o_p2_addr,
	output logic [engine_pkg::ADDR_W-1:0] o_p3_addr,
	output logic [engine_pkg::ADDR_W-1:0] o_p0_addr,
	output engine_pkg::word_t             o_dma_p0_ib_data,
	output logic                          o_dma_p0_ib_valid
);

	logic              res_valid;   // Result atom strobe
	engine_pkg::atom_t res;
	logic              wb_busy;     // Writeback still draining

	atom_if atom_bus ();   // Fetch side to compute lanes

	dma_deserializer u_deser (
		.clk                 (clk),
		.rst                 (rst),
		.i_engine_valid      (i_engine_valid),
		.i_op_type           (i_op_type),
		.i_kernel_size       (i_kernel_size),
		.i_out_count         (i_out_count),
		.i_data_start_addr   (i_data_start_addr),
		.i_weight_start_addr (i_weight_start_addr),
		.i_dma_p2_ob_data    (i_dma_p2_ob_data),
		.i_dma_p3_ob_data    (i_dma_p3_ob_data),
		.i_dma_p2_ob_we      (i_dma_p2_ob_we),
		.i_dma_p3_ob_we      (i_dma_p3_ob_we),
		.o_dma_p2_reads_en   (o_dma_p2_reads_en),
		.o_dma_p3_reads_en   (o_dma_p3_reads_en),
		.o_p2_addr           (o_p2_addr),
		.o_p3_addr           (o_p3_addr),
		.atom                (atom_bus.src)
	);

	mac_pool_array u_array (
		.clk         (clk),
		.rst         (rst),
		.i_op_type   (i_op_type),
		.i_ave_shift (i_ave_shift),
		.i_wb_busy   (wb_busy),
		.o_res_valid (res_valid),
		.o_res       (res),
		.atom        (atom_bus.dst)
	);

	writeback_serializer u_wb (
		.clk                 (clk),
		.rst                 (rst),
		.i_engine_valid      (i_engine_valid),
		.i_out_count         (i_out_count),
		.i_result_start_addr (i_result_start_addr),
		.i_res_valid         (res_valid),
		.i_res               (res),
		.i_dma_p0_ib_re      (i_dma_p0_ib_re),
		.o_wb_busy           (wb_busy),
		.o_dma_p0_writes_en  (o_dma_p0_writes_en),
		.o_p0_addr           (o_p0_addr),
		.o_dma_p0_ib_data    (o_dma_p0_ib_data),
		.o_dma_p0_ib_valid   (o_dma_p0_ib_valid),
		.o_engine_ready      (o_engine_ready)
	);

endmodule

// File: design/writeback_serializer.sv
`timescale 1ns/1ns

module writeback_serializer (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_engine_valid,
	input  logic [engine_pkg::CNT_W-1:0]  i_out_count,
	input  logic [engine_pkg::ADDR_W-1:0] i_result_start_addr,
	input  logic                          i_res_valid,
	input  engine_pkg::atom_t             i_res,
	input  logic                          i_dma_p0_ib_re,
	output logic                          o_wb_busy,
	output logic                          o_dma_p0_writes_en,
	output logic [engine_pkg::ADDR_W-1:0] o_p0_addr,
	output engine_pkg::word_t             o_dma_p0_ib_data,
	output logic                          o_dma_p0_ib_valid,
	output logic                          o_engine_ready
);

	logic                          layer_on;
	logic                          busy;        // Result atom held and being sent
	logic                          sent_last;   // Marks ib_valid of the last lane
	logic [engine_pkg::LANE_W-1:0] lane;
	logic [engine_pkg::CNT_W-1:0]  out_cnt;     // Outputs fully written
	engine_pkg::atom_t             rbuf;
	logic                          take;

	assign take               = i_dma_p0_ib_re & busy;
	assign o_wb_busy          = busy;
	assign o_dma_p0_writes_en = busy;

	always_ff @(posedge clk) begin
		if (i_res_valid)
			rbuf <= i_res;
		if (take)
			o_dma_p0_ib_data <= rbuf[lane];   // Lane k on the k-th read
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			layer_on          <= 1'b0;
			busy              <= 1'b0;
			sent_last         <= 1'b0;
			lane              <= '0;
			out_cnt           <= '0;
			o_p0_addr         <= '0;
			o_dma_p0_ib_valid <= 1'b0;
			o_engine_ready    <= 1'b0;
		end else begin
			o_dma_p0_ib_valid <= take;   // Exactly one cycle after ib_re
			sent_last         <= take && (lane == engine_pkg::LAST_LANE);
			if (!i_engine_valid) begin
				// Back to idle, ready drops with engine_valid
				layer_on       <= 1'b0;
				busy           <= 1'b0;
				o_engine_ready <= 1'b0;
			end else if (!layer_on) begin
				layer_on  <= 1'b1;
				lane      <= '0;
				out_cnt   <= '0;
				o_p0_addr <= i_result_start_addr;
			end else begin
				if (i_res_valid)
					busy <= 1'b1;
				else if (take && (lane == engine_pkg::LAST_LANE))
					busy <= 1'b0;   // Writes_en off while the last word is valid
				if (take)
					lane <= lane + 1'b1;
				if (o_dma_p0_ib_valid)
					o_p0_addr <= o_p0_addr + 1'b1;   // Advance after the word is taken
				if (sent_last) begin
					out_cnt <= out_cnt + 1'b1;
					if (out_cnt + 1'b1 == i_out_count)
						o_engine_ready <= 1'b1;   // Layer done
				end
			end
		end
	end

endmodule

// File: design/mac_pool_array.sv
`timescale 1ns/1ns

module mac_pool_array (
	input  logic              clk,
	input  logic              rst,
	input  logic [2:0]        i_op_type,
	input  logic [3:0]        i_ave_shift,
	input  logic              i_wb_busy,
	output logic              o_res_valid,
	output engine_pkg::atom_t o_res,
	atom_if.dst               atom
);

	logic is_max, is_avg;

	assign is_max = (i_op_type == engine_pkg::OP_MPOOL);
	assign is_avg = (i_op_type == engine_pkg::OP_APOOL);

	// Stall while a result is on its way out or still being sent
	assign atom.hold = i_wb_busy | o_res_valid | (atom.valid & atom.last);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_res_valid <= 1'b0;
		else
			o_res_valid <= atom.valid & atom.last;   // Cycle after the last tap
	end

	genvar k;
	generate
		for (k = 0; k < engine_pkg::LANES; k = k + 1) begin : g_lane
			engine_pkg::word_t                    acc, acc_nxt;
			engine_pkg::word_t                    res_q;
			logic signed [2*engine_pkg::WORD_W-1:0] prod;

			assign prod     = atom.data[k] * atom.weight[k];
			assign o_res[k] = res_q;

			always_comb begin
				if (is_max || is_avg) begin
					if (atom.first)
						acc_nxt = atom.data[k];   // Pools start from the first sample
					else if (is_max)
						acc_nxt = (atom.data[k] > acc) ? atom.data[k] : acc;
					else
						acc_nxt = acc + atom.data[k];
				end else if (atom.first) begin
					acc_nxt = prod[engine_pkg::WORD_W-1:0];   // Low half, wraps
				end else begin
					acc_nxt = acc + prod[engine_pkg::WORD_W-1:0];
				end
			end

			always_ff @(posedge clk) begin
				if (atom.valid) begin
					acc <= acc_nxt;
					if (atom.last)
						res_q <= is_avg ? (acc_nxt >>> i_ave_shift) : acc_nxt;
				end
			end
		end
	endgenerate

endmodule

// File: design/dma_deserializer.sv
`timescale 1ns/1ns

module dma_deserializer (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_engine_valid,
	input  logic [2:0]                    i_op_type,
	input  logic [7:0]                    i_kernel_size,
	input  logic [engine_pkg::CNT_W-1:0]  i_out_count,
	input  logic [engine_pkg::ADDR_W-1:0] i_data_start_addr,
	input  logic [engine_pkg::ADDR_W-1:0] i_weight_start_addr,
	input  engine_pkg::word_t             i_dma_p2_ob_data,
	input  engine_pkg::word_t             i_dma_p3_ob_data,
	input  logic                          i_dma_p2_ob_we,
	input  logic                          i_dma_p3_ob_we,
	output logic                          o_dma_p2_reads_en,
	output logic                          o_dma_p3_reads_en,
	output logic [engine_pkg::ADDR_W-1:0] o_p2_addr,
	output logic [engine_pkg::ADDR_W-1:0] o_p3_addr,
	atom_if.src                           atom
);

	logic                          layer_on;   // Layer accepted, waits for engine_valid low
	logic                          fetch_on;   // Still outputs left to fetch
	logic                          d_full;     // Data lanes complete, not yet issued
	logic                          w_full;     // Weight lanes complete, not yet issued
	logic [engine_pkg::LANE_W-1:0] d_lane;
	logic [engine_pkg::LANE_W-1:0] w_lane;
	logic [7:0]                    tap;        // Tap of the atom being assembled
	logic [engine_pkg::CNT_W-1:0]  out_cnt;
	engine_pkg::atom_t             dbuf, wbuf;
	engine_pkg::atom_t             dbuf_nxt, wbuf_nxt;
	logic                          need_w, d_we, w_we, d_fin, w_fin;
	logic                          complete, issue, tap_last;

	// Pool ops never touch the weight port
	assign need_w = (i_op_type != engine_pkg::OP_MPOOL) && (i_op_type != engine_pkg::OP_APOOL);

	assign o_dma_p2_reads_en = fetch_on & ~d_full;
	assign o_dma_p3_reads_en = fetch_on & need_w & ~w_full;

	assign d_we  = i_dma_p2_ob_we & o_dma_p2_reads_en;   // Accepted words only
	assign w_we  = i_dma_p3_ob_we & o_dma_p3_reads_en;
	assign d_fin = d_we && (d_lane == engine_pkg::LAST_LANE);
	assign w_fin = w_we && (w_lane == engine_pkg::LAST_LANE);

	// Atom is whole when both halves are in or arrive this cycle
	assign complete = fetch_on && (d_full || d_fin) && (!need_w || w_full || w_fin);
	assign issue    = complete && !atom.hold;
	assign tap_last = (tap + 8'd1 == i_kernel_size);

	// Merge this cycle's word so the atom can leave on the same edge
	always_comb begin
		dbuf_nxt = dbuf;
		wbuf_nxt = wbuf;
		if (d_we)
			dbuf_nxt[d_lane] = i_dma_p2_ob_data;
		if (w_we)
			wbuf_nxt[w_lane] = i_dma_p3_ob_data;
	end

	always_ff @(posedge clk) begin
		dbuf <= dbuf_nxt;
		wbuf <= wbuf_nxt;
		if (issue) begin
			atom.data   <= dbuf_nxt;
			atom.weight <= wbuf_nxt;
			atom.first  <= (tap == 8'd0);
			atom.last   <= tap_last;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			layer_on   <= 1'b0;
			fetch_on   <= 1'b0;
			d_full     <= 1'b0;
			w_full     <= 1'b0;
			d_lane     <= '0;
			w_lane     <= '0;
			tap        <= '0;
			out_cnt    <= '0;
			o_p2_addr  <= '0;
			o_p3_addr  <= '0;
			atom.valid <= 1'b0;
		end else begin
			atom.valid <= issue;   // One cycle after the completing strobe
			if (!i_engine_valid) begin
				layer_on <= 1'b0;
				fetch_on <= 1'b0;
			end else if (!layer_on) begin
				// New layer, start both streams from their bases
				layer_on  <= 1'b1;
				fetch_on  <= 1'b1;
				d_full    <= 1'b0;
				w_full    <= 1'b0;
				d_lane    <= '0;
				w_lane    <= '0;
				tap       <= '0;
				out_cnt   <= '0;
				o_p2_addr <= i_data_start_addr;
				o_p3_addr <= i_weight_start_addr;
			end else begin
				if (d_we) begin
					d_lane    <= d_lane + 1'b1;
					o_p2_addr <= o_p2_addr + 1'b1;   // Data is one linear stream
				end
				if (w_we)
					w_lane <= w_lane + 1'b1;
				if (issue && tap_last)
					o_p3_addr <= i_weight_start_addr;   // Same weights for every output
				else if (w_we)
					o_p3_addr <= o_p3_addr + 1'b1;
				if (issue) begin
					d_full <= 1'b0;
					w_full <= 1'b0;
					if (tap_last) begin
						tap     <= '0;
						out_cnt <= out_cnt + 1'b1;
						if (out_cnt + 1'b1 == i_out_count)
							fetch_on <= 1'b0;   // Last output fetched
					end else begin
						tap <= tap + 8'd1;
					end
				end else begin
					if (d_fin)
						d_full <= 1'b1;
					if (w_fin)
						w_full <= 1'b1;
				end
			end
		end
	end

endmodule

// File: design/atom_if.sv
`timescale 1ns/1ns

// One atom of data and weights on its way to the compute lanes
interface atom_if;

	engine_pkg::atom_t data;     // Activation lanes
	engine_pkg::atom_t weight;   // Weight lanes, CONV only
	logic              valid;    // One-cycle strobe
	logic              first;    // First tap of an output
	logic              last;     // Last tap of an output
	logic              hold;     // Consumer cannot take a new atom

	modport src (
		output data, weight, valid, first, last,
		input  hold
	);

	modport dst (
		input  data, weight, valid, first, last,
		output hold
	);

endinterface

// File: design/engine_pkg.sv
package engine_pkg;

	// Atom geometry
	localparam int LANES  = 4;               // Parallel channels per atom
	localparam int LANE_W = $clog2(LANES);   // Lane index width
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(LANES - 1);

	// Bus widths
	localparam int WORD_W = 16;   // DMA data word
	localparam int ADDR_W = 30;   // DMA word address
	localparam int CNT_W  = 16;   // Output counter

	// Operation codes, anything else runs as CONV
	localparam logic [2:0] OP_CONV  = 3'd1;
	localparam logic [2:0] OP_MPOOL = 3'd4;
	localparam logic [2:0] OP_APOOL = 3'd5;

	typedef logic signed [WORD_W-1:0] word_t;   // One signed sample
	typedef word_t [LANES-1:0] atom_t;         // LANES samples side by side

endpackage
